/* design/gfMulPkg.sv */
/*
  Shared definitions for the GF(2^26) Karatsuba multiplier:
  field and product widths, the default field polynomial,
  lane names and the per-lane operand pair struct.
*/
`default_nettype none

package gfMulPkg;

  // width of one field element
  localparam int FIELD_WIDTH = 26;

  // the Karatsuba split works on two halves of this width
  localparam int HALF_WIDTH = 13;

  // a 13x13 carry-less product has degree 24
  localparam int PART_WIDTH = 2 * HALF_WIDTH - 1;

  // the full unreduced product has degree 50
  localparam int PROD_WIDTH = 2 * FIELD_WIDTH - 1;

  localparam int NUM_LANES = 3;

  // x^26 + x^6 + x^2 + x + 1, the top bit included
  localparam logic [FIELD_WIDTH:0] DEFAULT_FIELD_POLY = 27'h400_0047;

  // role of each partial-product lane
  typedef enum logic [1:0] {
    LANE_LO  = 2'd0,
    LANE_HI  = 2'd1,
    LANE_MID = 2'd2
  } laneIdx_e;

  // operand pair handed to one lane
  typedef struct packed {
    logic [HALF_WIDTH-1:0] aOp;
    logic [HALF_WIDTH-1:0] bOp;
  } lanePair_t;

endpackage

`default_nettype wire

/* design/ksSplit.sv */
/*
  Operand splitter: registers both field elements as three
  13-bit operand pairs, one per Karatsuba lane.
*/
`timescale 1ns/1ps
`default_nettype none

module ksSplit import gfMulPkg::*; (
  input  wire                          clk,
  input  wire                          rstN,
  input  logic                         inValid,
  input  logic [FIELD_WIDTH-1:0]       inA,
  input  logic [FIELD_WIDTH-1:0]       inB,
  output lanePair_t [NUM_LANES-1:0]    lanePairs,
  output logic                         splitValid
);

  logic [HALF_WIDTH-1:0] aLo;
  logic [HALF_WIDTH-1:0] aHi;
  logic [HALF_WIDTH-1:0] bLo;
  logic [HALF_WIDTH-1:0] bHi;

  assign aLo = inA[HALF_WIDTH-1:0];
  assign aHi = inA[FIELD_WIDTH-1:HALF_WIDTH];
  assign bLo = inB[HALF_WIDTH-1:0];
  assign bHi = inB[FIELD_WIDTH-1:HALF_WIDTH];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      splitValid <= 1'b0;
      lanePairs  <= '0;
    end else begin
      splitValid <= inValid;
      if (inValid) begin
        lanePairs[LANE_LO].aOp <= aLo;
        lanePairs[LANE_LO].bOp <= bLo;
        lanePairs[LANE_HI].aOp <= aHi;
        lanePairs[LANE_HI].bOp <= bHi;
        // the middle lane multiplies (aHi + aLo)(bHi + bLo) in GF(2)
        lanePairs[LANE_MID].aOp <= aHi ^ aLo;
        lanePairs[LANE_MID].bOp <= bHi ^ bLo;
      end
    end
  end

endmodule

`default_nettype wire

/* design/ksMul13.sv */
/*
  One Karatsuba lane: a 13x13 schoolbook carry-less multiplier
  with a registered product and strobe.
*/
`timescale 1ns/1ps
`default_nettype none

module ksMul13 import gfMulPkg::*; (
  input  wire                    clk,
  input  wire                    rstN,
  input  lanePair_t              pairIn,
  input  logic                   pairValid,
  output logic [PART_WIDTH-1:0]  partProd,
  output logic                   laneValid
);

  logic [PART_WIDTH-1:0] prodComb;

  // each product bit k collects every aOp[i] & bOp[j] with i + j == k
  always_comb begin
    prodComb = '0;
    for (int i = 0; i < HALF_WIDTH; i++) begin
      for (int j = 0; j < HALF_WIDTH; j++) begin
        prodComb[i+j] = prodComb[i+j] ^ (pairIn.aOp[i] & pairIn.bOp[j]);
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      laneValid <= 1'b0;
      partProd  <= '0;
    end else begin
      laneValid <= pairValid;
      if (pairValid) begin
        partProd <= prodComb;
      end
    end
  end

endmodule

`default_nettype wire

/* design/ksCombine.sv */
/*
  Karatsuba combiner: merges the low, high and middle lane
  products into the registered 51-bit carry-less product.
*/
`timescale 1ns/1ps
`default_nettype none

module ksCombine import gfMulPkg::*; (
  input  wire                                  clk,
  input  wire                                  rstN,
  input  logic [NUM_LANES-1:0][PART_WIDTH-1:0] partProd,
  input  logic                                 partValid,
  output logic [PROD_WIDTH-1:0]                fullProd,
  output logic                                 combValid
);

  logic [PART_WIDTH-1:0] loProd;
  logic [PART_WIDTH-1:0] hiProd;
  logic [PART_WIDTH-1:0] midProd;
  logic [PART_WIDTH-1:0] midTerm;
  logic [PROD_WIDTH-1:0] combProd;

  assign loProd  = partProd[LANE_LO];
  assign hiProd  = partProd[LANE_HI];
  assign midProd = partProd[LANE_MID];

  // (aH+aL)(bH+bL) - aH*bH - aL*bL leaves the cross terms only
  assign midTerm = midProd ^ loProd ^ hiProd;

  // result = L + (midTerm << 13) + (H << 26), written out per bit range
  always_comb begin
    // bits 0..12 come from the low product alone
    combProd[HALF_WIDTH-1:0] = loProd[HALF_WIDTH-1:0];

    // bits 13..24 overlap the low product and the middle term
    combProd[PART_WIDTH-1:HALF_WIDTH] =
      loProd[PART_WIDTH-1:HALF_WIDTH] ^ midTerm[PART_WIDTH-HALF_WIDTH-1:0];

    // bit 25 only sees the middle term
    combProd[PART_WIDTH] = midTerm[HALF_WIDTH-1];

    // bits 26..37 overlap the middle term and the high product
    combProd[PART_WIDTH+HALF_WIDTH-1:FIELD_WIDTH] =
      midTerm[PART_WIDTH-1:HALF_WIDTH] ^ hiProd[PART_WIDTH-HALF_WIDTH-1:0];

    // bits 38..50 are the top of the high product
    combProd[PROD_WIDTH-1:PART_WIDTH+HALF_WIDTH] =
      hiProd[PART_WIDTH-1:HALF_WIDTH-1];
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      combValid <= 1'b0;
      fullProd  <= '0;
    end else begin
      combValid <= partValid;
      if (partValid) begin
        fullProd <= combProd;
      end
    end
  end

endmodule

`default_nettype wire

/* design/gfReduce.sv */
/*
  Field reduction: folds the 51-bit carry-less product modulo
  the field polynomial and registers the 26-bit remainder.
*/
`timescale 1ns/1ps
`default_nettype none

module gfReduce import gfMulPkg::*; #(
  parameter logic [FIELD_WIDTH:0] FIELD_POLY = DEFAULT_FIELD_POLY
) (
  input  wire                     clk,
  input  wire                     rstN,
  input  logic [PROD_WIDTH-1:0]   prodIn,
  input  logic                    prodValid,
  output logic [FIELD_WIDTH-1:0]  outProd,
  output logic                    outValid
);

  // the polynomial zero-extended to the product width
  localparam logic [PROD_WIDTH-1:0] POLY_EXT = PROD_WIDTH'(FIELD_POLY);

  logic [PROD_WIDTH-1:0] remComb;

  // fold from the top bit down, so bits raised by a fold
  // above degree 25 are cleared by a later pass of the loop
  always_comb begin
    remComb = prodIn;
    for (int k = PROD_WIDTH - 1; k >= FIELD_WIDTH; k--) begin
      if (remComb[k]) begin
        remComb = remComb ^ (POLY_EXT << (k - FIELD_WIDTH));
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
      outProd  <= '0;
    end else begin
      outValid <= prodValid;
      if (prodValid) begin
        outProd <= remComb[FIELD_WIDTH-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* design/gfMulTop.sv */
/*
  GF(2^26) multiplier top level: operand splitter, three
  carry-less lanes, Karatsuba combiner and field reduction.
  Four register stages, one operation per clock.
*/
`timescale 1ns/1ps
`default_nettype none

module gfMulTop import gfMulPkg::*; #(
  parameter logic [FIELD_WIDTH:0] FIELD_POLY = DEFAULT_FIELD_POLY
) (
  input  wire                     clk,
  input  wire                     rstN,
  input  logic                    inValid,
  input  logic [FIELD_WIDTH-1:0]  inA,
  input  logic [FIELD_WIDTH-1:0]  inB,
  output logic                    outValid,
  output logic [FIELD_WIDTH-1:0]  outProd
);

  lanePair_t [NUM_LANES-1:0]          lanePairs;
  logic                               splitValid;
  logic [NUM_LANES-1:0][PART_WIDTH-1:0] partProd;
  logic [NUM_LANES-1:0]               laneValid;
  logic [PROD_WIDTH-1:0]              fullProd;
  logic                               combValid;

  // stage 1
  ksSplit uSplit (
    .clk        (clk),
    .rstN       (rstN),
    .inValid    (inValid),
    .inA        (inA),
    .inB        (inB),
    .lanePairs  (lanePairs),
    .splitValid (splitValid)
  );

  // stage 2, the lanes are identical and only differ in their operands
  for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
    ksMul13 uLane (
      .clk       (clk),
      .rstN      (rstN),
      .pairIn    (lanePairs[i]),
      .pairValid (splitValid),
      .partProd  (partProd[i]),
      .laneValid (laneValid[i])
    );
  end

  // stage 3, the lanes run in lockstep so one strobe stands for all
  ksCombine uCombine (
    .clk       (clk),
    .rstN      (rstN),
    .partProd  (partProd),
    .partValid (laneValid[LANE_LO]),
    .fullProd  (fullProd),
    .combValid (combValid)
  );

  // stage 4
  gfReduce #(
    .FIELD_POLY (FIELD_POLY)
  ) uReduce (
    .clk       (clk),
    .rstN      (rstN),
    .prodIn    (fullProd),
    .prodValid (combValid),
    .outProd   (outProd),
    .outValid  (outValid)
  );

endmodule

`default_nettype wire

/* tests/gfMul_properties.sv */
/*
  Concurrent checks bound into gfMulTop: quiet output after reset,
  one-cycle strobe delay per stage and lanes in lockstep.
*/
`timescale 1ns/1ps
`default_nettype none

module gfMulProps import gfMulPkg::*; (
  input wire                   clk,
  input wire                   rstN,
  input logic                  inValid,
  input logic                  splitValid,
  input logic [NUM_LANES-1:0]  laneValid,
  input logic                  combValid,
  input logic                  outValid
);

  logic       seenIn;
  logic [3:0] inHist;

  // inHist[s] holds inValid as it was s + 1 edges ago
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      seenIn <= 1'b0;
      inHist <= '0;
    end else begin
      inHist <= {inHist[2:0], inValid};
      if (inValid) begin
        seenIn <= 1'b1;
      end
    end
  end

  quietInReset: assert property (@(posedge clk) !rstN |-> !outValid)
    else $error("outValid high during reset");

  quietBeforeInput: assert property (@(posedge clk) disable iff (!rstN) !seenIn |-> !outValid)
    else $error("outValid high before any inValid");

  splitDelay: assert property (@(posedge clk) disable iff (!rstN) splitValid == inHist[0])
    else $error("splitValid does not follow inValid by one cycle");

  laneLockstep: assert property (@(posedge clk) disable iff (!rstN)
    laneValid == {NUM_LANES{inHist[1]}})
    else $error("lane strobes out of step");

  combDelay: assert property (@(posedge clk) disable iff (!rstN) combValid == inHist[2])
    else $error("combValid does not follow inValid by three cycles");

  outLatency: assert property (@(posedge clk) disable iff (!rstN) outValid == inHist[3])
    else $error("outValid does not follow inValid by four cycles");

endmodule

bind gfMulTop gfMulProps uProps (
  .clk        (clk),
  .rstN       (rstN),
  .inValid    (inValid),
  .splitValid (splitValid),
  .laneValid  (laneValid),
  .combValid  (combValid),
  .outValid   (outValid)
);

`default_nettype wire

/* tests/gfMulTb.sv */
/*
  Testbench for the GF(2^26) multiplier: clock, reset, xorshift
  stimulus, reference model, expected-result queue and watchdog.
*/
`timescale 1ns/1ps
`default_nettype none

module gfMulTb import gfMulPkg::*;;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 2;
  localparam int NUM_RANDOM   = 300;
  localparam int NUM_EDGE     = 12;
  localparam int NUM_BURST    = 50;
  localparam int NUM_GAPPY    = 40;
  localparam int MAX_GAP      = 3;
  localparam int PHASE_GAP    = 3;
  localparam int DRAIN_CYCLES = 20;

  // longest the whole sequence can take, gaps included
  localparam int TEST_CYCLES = RESET_CYCLES + NUM_RANDOM + NUM_EDGE + NUM_BURST
                             + NUM_GAPPY * (MAX_GAP + 1) + 4 * PHASE_GAP + DRAIN_CYCLES;

  logic                   clk;
  logic                   rstN;
  logic                   inValid;
  logic [FIELD_WIDTH-1:0] inA;
  logic [FIELD_WIDTH-1:0] inB;
  logic                   outValid;
  logic [FIELD_WIDTH-1:0] outProd;

  logic [FIELD_WIDTH-1:0] expQ[$];
  logic [31:0]            rngState;
  int                     issueCount;
  int                     checkCount;

  gfMulTop u_dut (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .inA      (inA),
    .inB      (inB),
    .outValid (outValid),
    .outProd  (outProd)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic drawRandom(output logic [31:0] r);
    rngState = xorshift32(rngState);
    r = rngState;
  endtask

  // plain polynomial product over GF(2), one shifted copy of a per set bit of b
  function automatic logic [PROD_WIDTH-1:0] clmul(input logic [FIELD_WIDTH-1:0] a,
                                                  input logic [FIELD_WIDTH-1:0] b);
    logic [PROD_WIDTH-1:0] p;
    p = '0;
    for (int i = 0; i < FIELD_WIDTH; i++) begin
      if (b[i]) begin
        p = p ^ (PROD_WIDTH'(a) << i);
      end
    end
    return p;
  endfunction

  // remainder modulo the field polynomial, clearing the top bits one by one
  function automatic logic [FIELD_WIDTH-1:0] reduceMod(input logic [PROD_WIDTH-1:0] p);
    logic [PROD_WIDTH-1:0] r;
    r = p;
    for (int k = PROD_WIDTH - 1; k >= FIELD_WIDTH; k--) begin
      if (r[k]) begin
        r = r ^ (PROD_WIDTH'(DEFAULT_FIELD_POLY) << (k - FIELD_WIDTH));
      end
    end
    return r[FIELD_WIDTH-1:0];
  endfunction

  task automatic issueExpect(input logic [FIELD_WIDTH-1:0] a, input logic [FIELD_WIDTH-1:0] b,
                             input logic [FIELD_WIDTH-1:0] expected);
    @(posedge clk);
    inValid <= 1'b1;
    inA     <= a;
    inB     <= b;
    expQ.push_back(expected);
    issueCount++;
  endtask

  task automatic issueOp(input logic [FIELD_WIDTH-1:0] a, input logic [FIELD_WIDTH-1:0] b);
    issueExpect(a, b, reduceMod(clmul(a, b)));
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      inValid <= 1'b0;
    end
  endtask

  // outputs are compared half a cycle after they change
  always @(negedge clk) begin
    logic [FIELD_WIDTH-1:0] expHead;
    if (rstN && outValid) begin
      if (expQ.size() == 0) begin
        failRun("outValid went high with no operation outstanding");
      end else begin
        expHead = expQ.pop_front();
        checkCount++;
        assert (outProd == expHead)
          else failRun($sformatf("CHECK FAILED outProd got 0x%07h expected 0x%07h",
                                 outProd, expHead));
      end
    end
  end

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    failRun("watchdog expired before all results came back");
  end

  initial begin
    logic [31:0] ra;
    logic [31:0] rb;
    clk        = 1'b0;
    rstN       = 1'b0;
    inValid    = 1'b0;
    inA        = '0;
    inB        = '0;
    rngState   = 32'h13ee;
    issueCount = 0;
    checkCount = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstN <= 1'b1;
    idleCycles(PHASE_GAP);

    // random operand pairs, back to back
    for (int n = 0; n < NUM_RANDOM; n++) begin
      drawRandom(ra);
      drawRandom(rb);
      issueOp(ra[FIELD_WIDTH-1:0], rb[FIELD_WIDTH-1:0]);
    end
    idleCycles(PHASE_GAP);

    // identities give their value directly, edges go through the model
    drawRandom(ra);
    drawRandom(rb);
    issueExpect(ra[FIELD_WIDTH-1:0], 26'd1, ra[FIELD_WIDTH-1:0]);
    issueExpect(26'd1, rb[FIELD_WIDTH-1:0], rb[FIELD_WIDTH-1:0]);
    issueExpect(ra[FIELD_WIDTH-1:0], 26'd0, 26'd0);
    issueExpect(26'd0, rb[FIELD_WIDTH-1:0], 26'd0);
    issueOp('1, '1);
    issueOp(26'h3ffe000, 26'h3ffe000);
    issueOp(26'h2000000, 26'h2000000);
    issueOp(26'h3ffe000, 26'h0001fff);
    issueOp(26'h0001fff, 26'h0001fff);
    issueOp({ra[HALF_WIDTH-1:0], 13'd0}, {rb[HALF_WIDTH-1:0], 13'd0});
    issueOp({rb[HALF_WIDTH-1:0], 13'd0}, '1);
    issueOp(26'd1, 26'd1);
    idleCycles(PHASE_GAP);

    for (int n = 0; n < NUM_BURST; n++) begin
      drawRandom(ra);
      drawRandom(rb);
      issueOp(ra[FIELD_WIDTH-1:0], rb[FIELD_WIDTH-1:0]);
    end
    idleCycles(PHASE_GAP);

    // burst with up to MAX_GAP idle cycles between strobes
    for (int n = 0; n < NUM_GAPPY; n++) begin
      drawRandom(ra);
      drawRandom(rb);
      issueOp(ra[FIELD_WIDTH-1:0], rb[FIELD_WIDTH-1:0]);
      idleCycles(int'(ra[31:30]) % (MAX_GAP + 1));
    end
    idleCycles(1);

    // every result is due four cycles after its strobe
    repeat (8) @(negedge clk);

    if (expQ.size() != 0) begin
      failRun($sformatf("%0d operations issued but %0d results checked",
                        issueCount, checkCount));
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
design/gfMulPkg.sv
design/ksSplit.sv
design/ksMul13.sv
design/ksCombine.sv
design/gfReduce.sv
design/gfMulTop.sv
tests/gfMul_properties.sv
tests/gfMulTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the GF(2^26) multiplier testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module gfMulTb \
  -Mdir "$BUILD_DIR"

# the simulator exits non-zero on a failure, the log decides the result
"./$BUILD_DIR/VgfMulTb" > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -q "^Simulation PASSED$" "$LOG_FILE"; then
  echo "run.sh: test run passed"
  exit 0
else
  echo "run.sh: test run failed, see $LOG_FILE"
  exit 1
fi
